/* alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu
    import cpu_ctrl_pkg::*;
(
    input  word_t   src_a_i,      // rs1
    input  word_t   src_b_i,      // rs2 or immediate
    input  alu_op_e alu_ctrl_i,
    output word_t   result_o,
    output logic    branch_o      // branch taken
);

    logic [4:0] shamt;
    word_t      sum;
    word_t      diff;
    logic       lt_s;
    logic       lt_u;
    logic       eq;

    assign shamt = src_b_i[4:0];                  // rv32 shifts use 5 bits
    assign sum   = src_a_i + src_b_i;
    assign diff  = src_a_i - src_b_i;
    assign lt_s  = $signed(src_a_i) < $signed(src_b_i);
    assign lt_u  = src_a_i < src_b_i;
    assign eq    = (src_a_i == src_b_i);

    always_comb begin
        case (alu_ctrl_i)
            ALU_ADD, ALU_ADDR, ALU_JAL, ALU_JALR: result_o = sum;
            ALU_SUB:  result_o = diff;
            ALU_AND:  result_o = src_a_i & src_b_i;
            ALU_OR:   result_o = src_a_i | src_b_i;
            ALU_XOR:  result_o = src_a_i ^ src_b_i;
            ALU_SLT:  result_o = {{(XLEN-1){1'b0}}, lt_s};
            ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, lt_u};
            ALU_SRL:  result_o = src_a_i >> shamt;
            ALU_SLL:  result_o = src_a_i << shamt;
            ALU_SRA:  result_o = word_t'($signed(src_a_i) >>> shamt);
            default:  result_o = diff;            // branch compares, not written back
        endcase
    end

    always_comb begin
        case (alu_ctrl_i)
            ALU_BEQ:            branch_o = eq;
            ALU_BNE:            branch_o = !eq;
            ALU_BLT:            branch_o = lt_s;
            ALU_JAL, ALU_JALR:  branch_o = 1'b1;  // unconditional
            default:            branch_o = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* control.sv */
`timescale 1ns/1ps
`default_nettype none

module control
    import rv_isa_pkg::*;
    import cpu_ctrl_pkg::*;
(
    input  opcode_e  op_i,            // instr[6:0]
    input  logic [2:0] funct3_i,
    input  logic     funct7bit_i,     // instr[30]
    output logic     mem_write_en_o,  // store strobe
    output logic     reg_write_en_o,  // write-back strobe
    output alu_op_e  alu_ctrl_o,
    output logic     alu_src_o,       // 1 = immediate as operand b
    output imm_sel_e imm_src_o,
    output logic     branch_src_o,    // control transfer, alu flag picks the target
    output logic     addr_select_o,   // 1 = word, 0 = byte access
    output logic     result_src_o,    // 1 = memory data to rd
    output logic     jal_o,           // link, pc + 4 to rd (jal and jalr)
    output logic     jalr_o           // target from alu result
);

    always_comb begin
        // defaults behave as a no-op
        mem_write_en_o = 1'b0;
        reg_write_en_o = 1'b0;
        alu_ctrl_o     = ALU_ADD;
        alu_src_o      = 1'b0;
        imm_src_o      = IMM_I;
        branch_src_o   = 1'b0;
        addr_select_o  = 1'b1;
        result_src_o   = 1'b0;
        jal_o          = 1'b0;
        jalr_o         = 1'b0;

        case (op_i)
            OP_REG, OP_IMM: begin
                reg_write_en_o = 1'b1;
                alu_src_o      = (op_i == OP_IMM);
                case (funct3_i)
                    // bit 30 only means sub for the register form
                    3'b000: alu_ctrl_o = (funct7bit_i && op_i == OP_REG) ? ALU_SUB : ALU_ADD;
                    3'b001: alu_ctrl_o = ALU_SLL;
                    3'b010: alu_ctrl_o = ALU_SLT;
                    3'b011: alu_ctrl_o = ALU_SLTU;
                    3'b100: alu_ctrl_o = ALU_XOR;
                    3'b101: alu_ctrl_o = funct7bit_i ? ALU_SRA : ALU_SRL; // both forms
                    3'b110: alu_ctrl_o = ALU_OR;
                    default: alu_ctrl_o = ALU_AND;
                endcase
            end
            OP_LOAD: begin
                alu_ctrl_o   = ALU_ADDR;   // rs1 + imm
                alu_src_o    = 1'b1;
                result_src_o = 1'b1;
                case (funct3_i)
                    F3_BYTE: begin
                        addr_select_o  = 1'b0;
                        reg_write_en_o = 1'b1;
                    end
                    F3_WORD: reg_write_en_o = 1'b1;
                    default: ;             // lh, lbu, lhu retire as no-op
                endcase
            end
            OP_STORE: begin
                alu_ctrl_o = ALU_ADDR;
                alu_src_o  = 1'b1;
                imm_src_o  = IMM_S;
                case (funct3_i)
                    F3_BYTE: begin
                        addr_select_o  = 1'b0;
                        mem_write_en_o = 1'b1;
                    end
                    F3_WORD: mem_write_en_o = 1'b1;
                    default: ;             // sh not supported
                endcase
            end
            OP_BRANCH: begin
                imm_src_o    = IMM_B;      // compare rs1 against rs2
                branch_src_o = 1'b1;
                case (funct3_i)
                    F3_BEQ: alu_ctrl_o = ALU_BEQ;
                    F3_BNE: alu_ctrl_o = ALU_BNE;
                    F3_BLT: alu_ctrl_o = ALU_BLT;
                    default: branch_src_o = 1'b0; // bge, bltu, bgeu fall through
                endcase
            end
            OP_JALR: begin
                reg_write_en_o = 1'b1;
                alu_ctrl_o     = ALU_JALR; // rs1 + imm, flag forced
                alu_src_o      = 1'b1;
                branch_src_o   = 1'b1;
                jal_o          = 1'b1;
                jalr_o         = 1'b1;
            end
            OP_JAL: begin
                reg_write_en_o = 1'b1;
                alu_ctrl_o     = ALU_JAL;  // target comes from pc + imm
                alu_src_o      = 1'b1;
                imm_src_o      = IMM_J;
                branch_src_o   = 1'b1;
                jal_o          = 1'b1;
            end
            default: ;                     // lui, auipc, system, ...
        endcase
    end

endmodule

`default_nettype wire

/* cpu_ctrl_pkg.sv */
`default_nettype none

package cpu_ctrl_pkg;

    localparam int XLEN = 32;       // word width

    typedef logic [XLEN-1:0] word_t;

    // alu operation codes
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SUB  = 4'b0001,
        ALU_AND  = 4'b0010,
        ALU_OR   = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SLT  = 4'b0101,     // signed compare
        ALU_SLTU = 4'b0110,     // unsigned compare
        ALU_SRL  = 4'b0111,
        ALU_SLL  = 4'b1000,
        ALU_SRA  = 4'b1001,
        ALU_BLT  = 4'b1010,
        ALU_JAL  = 4'b1011,     // add, branch always
        ALU_JALR = 4'b1100,     // add, branch always
        ALU_BEQ  = 4'b1101,
        ALU_BNE  = 4'b1110,
        ALU_ADDR = 4'b1111      // address add for loads and stores
    } alu_op_e;

    localparam int DMEM_WORDS = 256;                // data ram depth
    localparam int DMEM_AW    = $clog2(DMEM_WORDS); // word index width

endpackage

`default_nettype wire

/* cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_top
    import rv_isa_pkg::*;
    import cpu_ctrl_pkg::*;
(
    input  logic      clk_i,
    input  logic      reset_i,
    input  word_t     instr_i,     // instruction at pc_o, same cycle
    output word_t     pc_o,
    output logic      wb_en_o,     // register write-back
    output reg_addr_t wb_addr_o,
    output word_t     wb_data_o,
    output logic      st_en_o,     // data memory store
    output word_t     st_addr_o,
    output word_t     st_data_o,
    output logic      st_word_o    // 1 = sw, 0 = sb
);

    word_t     pc;
    word_t     pc_next;
    word_t     pc_plus4;
    word_t     pc_target;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    logic      mem_write_en;
    logic      reg_write_en;
    alu_op_e   alu_ctrl;
    logic      alu_src;
    imm_sel_e  imm_src;
    logic      branch_src;
    logic      addr_select;
    logic      result_src;
    logic      jal;
    logic      jalr;
    logic      reg_we;
    logic      mem_we;
    word_t     imm;
    word_t     rd1;
    word_t     rd2;
    word_t     src_b;
    word_t     alu_result;
    logic      alu_branch;
    word_t     mem_rdata;
    word_t     wb_data;

    // field slicing
    assign rs1 = instr_i[19:15];
    assign rs2 = instr_i[24:20];
    assign rd  = instr_i[11:7];

    control control_inst (
        .op_i           (opcode_e'(instr_i[6:0])),
        .funct3_i       (instr_i[14:12]),
        .funct7bit_i    (instr_i[30]),
        .mem_write_en_o (mem_write_en),
        .reg_write_en_o (reg_write_en),
        .alu_ctrl_o     (alu_ctrl),
        .alu_src_o      (alu_src),
        .imm_src_o      (imm_src),
        .branch_src_o   (branch_src),
        .addr_select_o  (addr_select),
        .result_src_o   (result_src),
        .jal_o          (jal),
        .jalr_o         (jalr)
    );

    imm_extend imm_extend_inst (
        .instr_i   (instr_i),
        .imm_src_i (imm_src),
        .imm_o     (imm)
    );

    // no writes while reset is held
    assign reg_we = reg_write_en & ~reset_i;
    assign mem_we = mem_write_en & ~reset_i;

    reg_file reg_file_inst (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .rs1_i   (rs1),
        .rs2_i   (rs2),
        .rd_i    (rd),
        .we_i    (reg_we),
        .wd_i    (wb_data),
        .rd1_o   (rd1),
        .rd2_o   (rd2)
    );

    assign src_b = alu_src ? imm : rd2;   // operand b mux

    alu alu_inst (
        .src_a_i    (rd1),
        .src_b_i    (src_b),
        .alu_ctrl_i (alu_ctrl),
        .result_o   (alu_result),
        .branch_o   (alu_branch)
    );

    data_mem data_mem_inst (
        .clk_i  (clk_i),
        .we_i   (mem_we),
        .addr_i (alu_result),
        .wd_i   (rd2),
        .word_i (addr_select),
        .rd_o   (mem_rdata)
    );

    // link beats load beats alu result
    assign wb_data = jal ? pc_plus4 : (result_src ? mem_rdata : alu_result);

    assign pc_plus4  = pc + word_t'(XLEN / 8);
    assign pc_target = pc + imm;          // branch and jal target

    always_comb begin
        pc_next = pc_plus4;
        if (branch_src && alu_branch) begin
            pc_next = jalr ? {alu_result[XLEN-1:1], 1'b0} : pc_target;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pc <= '0;                     // fetch from 0 after reset
        end else begin
            pc <= pc_next;
        end
    end

    assign pc_o      = pc;
    assign wb_en_o   = reg_we;
    assign wb_addr_o = rd;
    assign wb_data_o = wb_data;
    assign st_en_o   = mem_we;
    assign st_addr_o = alu_result;
    assign st_data_o = rd2;
    assign st_word_o = addr_select;

endmodule

`default_nettype wire

/* data_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module data_mem
    import cpu_ctrl_pkg::*;
(
    input  logic  clk_i,
    input  logic  we_i,
    input  word_t addr_i,    // byte address
    input  word_t wd_i,
    input  logic  word_i,    // 1 = word, 0 = byte
    output word_t rd_o
);

    word_t              mem [0:DMEM_WORDS-1];
    logic [DMEM_AW-1:0] idx;
    logic [1:0]         lane;
    word_t              rd_word;
    logic [7:0]         rd_byte;

    assign idx  = addr_i[DMEM_AW+1:2];    // wraps modulo memory size
    assign lane = addr_i[1:0];            // ignored for word access

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            if (word_i) begin
                mem[idx] <= wd_i;
            end else begin
                mem[idx][8*lane +: 8] <= wd_i[7:0];  // other lanes kept
            end
        end
    end

    assign rd_word = mem[idx];
    assign rd_byte = rd_word[8*lane +: 8];          // little endian lane

    // lb sign-extends, lw returns the whole word
    assign rd_o = word_i ? rd_word : {{(XLEN-8){rd_byte[7]}}, rd_byte};

endmodule

`default_nettype wire

/* files.f */
rv_isa_pkg.sv
cpu_ctrl_pkg.sv
control.sv
imm_extend.sv
alu.sv
reg_file.sv
data_mem.sv
cpu_top.sv
tb_cpu_top.sv

/* imm_extend.sv */
`timescale 1ns/1ps
`default_nettype none

module imm_extend
    import rv_isa_pkg::*;
    import cpu_ctrl_pkg::*;
(
    input  word_t    instr_i,
    input  imm_sel_e imm_src_i,
    output word_t    imm_o
);

    always_comb begin
        case (imm_src_i)
            IMM_S: imm_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            IMM_B: imm_o = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                            instr_i[30:25], instr_i[11:8], 1'b0};   // halfword offset
            IMM_J: imm_o = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                            instr_i[20], instr_i[30:21], 1'b0};     // +-1 MiB
            default: imm_o = {{20{instr_i[31]}}, instr_i[31:20]};   // I format
        endcase
    end

endmodule

`default_nettype wire

/* reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file
    import rv_isa_pkg::*;
    import cpu_ctrl_pkg::*;
(
    input  logic      clk_i,
    input  logic      reset_i,
    input  reg_addr_t rs1_i,
    input  reg_addr_t rs2_i,
    input  reg_addr_t rd_i,
    input  logic      we_i,
    input  word_t     wd_i,
    output word_t     rd1_o,
    output word_t     rd2_o
);

    word_t regs [1:31];                   // no storage behind x0

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_i != 5'd0) begin
            regs[rd_i] <= wd_i;           // x0 writes dropped
        end
    end

    // async read, new value visible next cycle
    assign rd1_o = (rs1_i == 5'd0) ? '0 : regs[rs1_i];
    assign rd2_o = (rs2_i == 5'd0) ? '0 : regs[rs2_i];

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the cpu_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f files.f --top-module tb_cpu_top -o sim_cpu_top
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_cpu_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: PASS" "$LOG"; then
    exit 0
fi
exit 1

/* rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OP_REG    = 7'b0110011, // add, sub, sll ... and
        OP_IMM    = 7'b0010011, // addi ... andi, shifts by shamt
        OP_LOAD   = 7'b0000011, // lb, lw
        OP_STORE  = 7'b0100011, // sb, sw
        OP_BRANCH = 7'b1100011, // beq, bne, blt
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111
    } opcode_e;

    // load / store width in funct3
    localparam logic [2:0] F3_BYTE = 3'b000;
    localparam logic [2:0] F3_WORD = 3'b010;

    // branch conditions in funct3
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [2:0] F3_BLT = 3'b100;

    // immediate formats handed from decoder to extender
    typedef enum logic [2:0] {
        IMM_I = 3'b000,         // loads, op-imm, jalr
        IMM_S = 3'b001,         // stores
        IMM_B = 3'b010,         // branches, bit 0 zero
        IMM_J = 3'b100          // jal, bit 0 zero
    } imm_sel_e;

    typedef logic [4:0] reg_addr_t; // x0 .. x31

endpackage

`default_nettype wire

/* tb_cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_top
    import rv_isa_pkg::*;
    import cpu_ctrl_pkg::*;
;

    localparam int RESET_CYCLES = 5;
    localparam int NUM_TESTS    = 6;
    localparam int PROG_TOTAL   = 69;     // summed program lengths of all tests
    localparam int CYCLE_LIMIT  = 2 * PROG_TOTAL + NUM_TESTS * RESET_CYCLES;
    localparam word_t NOP       = 32'h0000_0013; // addi x0, x0, 0

    localparam logic [2:0] KIND_F3 [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3,
                                            3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
    localparam logic KIND_B30 [10] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0,
                                       1'b0, 1'b0, 1'b1, 1'b0, 1'b0};

    logic      clk_i;
    logic      reset_i;
    word_t     instr_i;
    word_t     pc_o;
    logic      wb_en_o;
    reg_addr_t wb_addr_o;
    word_t     wb_data_o;
    logic      st_en_o;
    word_t     st_addr_o;
    word_t     st_data_o;
    logic      st_word_o;

    word_t prog [$];                      // current program, word per instruction
    word_t rf [32];                       // model registers
    word_t mem_model [DMEM_WORDS];
    word_t model_pc;
    logic  checking;
    int    pass_cnt;
    int    fail_cnt;
    int    cycles;

    cpu_top cpu_top_inst (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .instr_i   (instr_i),
        .pc_o      (pc_o),
        .wb_en_o   (wb_en_o),
        .wb_addr_o (wb_addr_o),
        .wb_data_o (wb_data_o),
        .st_en_o   (st_en_o),
        .st_addr_o (st_addr_o),
        .st_data_o (st_data_o),
        .st_word_o (st_word_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;       // 20 ns period
    end

    // instruction encoders
    function automatic word_t r_type(input logic [2:0] f3, input logic b30, input reg_addr_t rd,
                                     input reg_addr_t rs1, input reg_addr_t rs2);
        return {1'b0, b30, 5'b0, rs2, rs1, f3, rd, 7'(OP_REG)};
    endfunction

    function automatic word_t i_type(input logic [6:0] op, input logic [2:0] f3,
                                     input reg_addr_t rd, input reg_addr_t rs1,
                                     input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t s_type(input logic [2:0] f3, input reg_addr_t rs1,
                                     input reg_addr_t rs2, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'(OP_STORE)};
    endfunction

    function automatic word_t b_type(input logic [2:0] f3, input reg_addr_t rs1,
                                     input reg_addr_t rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'(OP_BRANCH)};
    endfunction

    function automatic word_t j_type(input reg_addr_t rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'(OP_JAL)};
    endfunction

    function automatic word_t prog_at(input word_t addr);
        if ((addr >> 2) < prog.size()) begin
            return prog[addr >> 2];
        end
        return NOP;                       // past the end of the program
    endfunction

    // ISA reference, one instruction from the model state
    function automatic void iss_step(input word_t ins, output word_t npc, output logic wen,
                                     output reg_addr_t wa, output word_t wd, output logic sen,
                                     output word_t sa, output word_t sd, output logic sword);
        logic [6:0] op;
        logic [2:0] f3;
        word_t      a;
        word_t      b;
        word_t      imm_i;
        word_t      imm_s;
        word_t      imm_b;
        word_t      imm_j;
        word_t      addr;
        word_t      lw_val;
        logic [7:0] lb_val;
        logic       taken;
        op     = ins[6:0];
        f3     = ins[14:12];
        a      = rf[ins[19:15]];
        imm_i  = {{20{ins[31]}}, ins[31:20]};
        imm_s  = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b  = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j  = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        npc    = model_pc + 32'd4;
        wen    = 1'b0;
        wa     = ins[11:7];
        wd     = '0;
        sen    = 1'b0;
        sa     = '0;
        sd     = rf[ins[24:20]];
        sword  = 1'b1;
        taken  = 1'b0;
        case (op)
            OP_REG, OP_IMM: begin
                b   = (op == OP_REG) ? rf[ins[24:20]] : imm_i;
                wen = 1'b1;
                case (f3)
                    3'd0: wd = (op == OP_REG && ins[30]) ? a - b : a + b;
                    3'd1: wd = a << b[4:0];
                    3'd2: wd = word_t'($signed(a) < $signed(b));
                    3'd3: wd = word_t'(a < b);
                    3'd4: wd = a ^ b;
                    3'd5: wd = ins[30] ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
                    3'd6: wd = a | b;
                    default: wd = a & b;
                endcase
            end
            OP_LOAD: begin
                addr   = a + imm_i;
                lw_val = mem_model[addr[DMEM_AW+1:2]];
                lb_val = lw_val[8*addr[1:0] +: 8];
                if (f3 == F3_WORD) begin
                    wen = 1'b1;
                    wd  = lw_val;
                end else if (f3 == F3_BYTE) begin
                    wen = 1'b1;
                    wd  = {{24{lb_val[7]}}, lb_val};
                end
            end
            OP_STORE: begin
                sa    = a + imm_s;
                sen   = (f3 == F3_WORD) || (f3 == F3_BYTE);
                sword = (f3 == F3_WORD);
            end
            OP_BRANCH: begin
                b = rf[ins[24:20]];
                case (f3)
                    F3_BEQ: taken = (a == b);
                    F3_BNE: taken = (a != b);
                    F3_BLT: taken = ($signed(a) < $signed(b));
                    default: taken = 1'b0;
                endcase
                if (taken) npc = model_pc + imm_b;
            end
            OP_JAL: begin
                wen = 1'b1;
                wd  = model_pc + 32'd4;
                npc = model_pc + imm_j;
            end
            OP_JALR: begin
                wen = 1'b1;
                wd  = model_pc + 32'd4;
                npc = (a + imm_i) & ~32'd1;
            end
            default: ;                    // unsupported, no-op
        endcase
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("ERR %s expected %h got %h at pc %h", name, exp, act, model_pc);
            fail_cnt++;
        end else pass_cnt++;
    endtask

    task automatic check_reg(input string name, input reg_addr_t exp, input reg_addr_t act);
        if (act !== exp) begin
            $display("ERR %s expected %h got %h at pc %h", name, exp, act, model_pc);
            fail_cnt++;
        end else pass_cnt++;
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s expected %h got %h at pc %h", name, exp, act, model_pc);
            fail_cnt++;
        end else pass_cnt++;
    endtask

    // instruction fetch, just after the falling edge
    always @(negedge clk_i) begin
        #1 instr_i = prog_at(pc_o);
    end

    // compare just before the rising edge, then advance the model
    always begin : compare_proc
        word_t     npc;
        logic      wen;
        reg_addr_t wa;
        word_t     wd;
        logic      sen;
        word_t     sa;
        word_t     sd;
        logic      sword;
        @(negedge clk_i);
        #9;
        if (checking && reset_i) begin
            check_bit("wb_en_o", 1'b0, wb_en_o);
            check_bit("st_en_o", 1'b0, st_en_o);
        end else if (checking) begin
            iss_step(prog_at(model_pc), npc, wen, wa, wd, sen, sa, sd, sword);
            check_word("pc_o", model_pc, pc_o);
            check_bit("wb_en_o", wen, wb_en_o);
            if (wen) begin
                check_reg("wb_addr_o", wa, wb_addr_o);
                check_word("wb_data_o", wd, wb_data_o);
            end
            check_bit("st_en_o", sen, st_en_o);
            if (sen) begin
                check_word("st_addr_o", sa, st_addr_o);
                check_word("st_data_o", sd, st_data_o);
                check_bit("st_word_o", sword, st_word_o);
            end
            if (wen && wa != 5'd0) rf[wa] = wd;
            if (sen && sword) mem_model[sa[DMEM_AW+1:2]] = sd;
            if (sen && !sword) mem_model[sa[DMEM_AW+1:2]][8*sa[1:0] +: 8] = sd[7:0];
            model_pc = npc;
        end
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, program never reached its end", cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // reset, then run prog until the model falls off its end
    task automatic run_program(input string name);
        int errs0;
        errs0 = fail_cnt;
        @(negedge clk_i);
        reset_i  = 1'b1;
        checking = 1'b1;
        model_pc = '0;
        for (int i = 0; i < 32; i++) rf[i] = '0;
        repeat (RESET_CYCLES) @(negedge clk_i);
        reset_i = 1'b0;
        while (model_pc < word_t'(prog.size() * 4)) @(posedge clk_i);
        @(negedge clk_i);
        checking = 1'b0;
        $display("test %s done, %0d errors", name, fail_cnt - errs0);
    endtask

    initial begin
        reset_i  = 1'b1;
        instr_i  = NOP;
        checking = 1'b0;
        model_pc = '0;
        pass_cnt = 0;
        fail_cnt = 0;
        cycles   = 0;
        void'($urandom(15633));
        for (int i = 0; i < DMEM_WORDS; i++) mem_model[i] = '0;

        prog = {};                                    // reset, a store waits at pc 0
        prog.push_back(s_type(F3_WORD, 5'd0, 5'd0, 12'd0));
        prog.push_back(NOP);
        run_program("reset");

        prog = {};                                    // arithmetic, all kinds
        for (int r = 1; r <= 4; r++) begin
            prog.push_back(i_type(OP_IMM, 3'd0, reg_addr_t'(r), 5'd0, 12'($urandom)));
        end
        for (int k = 0; k < 10; k++) begin
            prog.push_back(r_type(KIND_F3[k], KIND_B30[k], reg_addr_t'(5 + k),
                                  reg_addr_t'(1 + $urandom % 4), reg_addr_t'(1 + $urandom % 4)));
        end
        for (int k = 0; k < 10; k++) begin
            if (k == 1) continue;                     // no subi
            prog.push_back(i_type(OP_IMM, KIND_F3[k], reg_addr_t'(15 + k),
                                  reg_addr_t'(1 + $urandom % 14),
                                  (KIND_F3[k] == 3'd1 || KIND_F3[k] == 3'd5) ?
                                  {1'b0, KIND_B30[k], 5'b0, 5'($urandom)} : 12'($urandom)));
        end
        prog.push_back(r_type(3'd0, 1'b0, 5'd0, 5'd1, 5'd2));   // write to x0
        prog.push_back(r_type(3'd0, 1'b0, 5'd30, 5'd0, 5'd1));  // x0 still reads zero
        run_program("arith");

        prog = {};                                    // loads and stores
        prog.push_back(i_type(OP_IMM, 3'd0, 5'd1, 5'd0, 12'(($urandom % 200) * 4)));
        prog.push_back(i_type(OP_IMM, 3'd0, 5'd2, 5'd0, 12'($urandom)));
        prog.push_back(i_type(OP_IMM, 3'd0, 5'd3, 5'd0, 12'($urandom)));
        prog.push_back(s_type(F3_WORD, 5'd1, 5'd2, 12'd0));
        prog.push_back(s_type(F3_WORD, 5'd1, 5'd3, 12'd4));
        prog.push_back(s_type(F3_BYTE, 5'd1, 5'd3, 12'd1));
        prog.push_back(s_type(F3_BYTE, 5'd1, 5'd2, 12'd6));
        prog.push_back(i_type(OP_LOAD, F3_WORD, 5'd4, 5'd1, 12'd0));
        prog.push_back(i_type(OP_LOAD, F3_BYTE, 5'd5, 5'd1, 12'd1));
        prog.push_back(i_type(OP_LOAD, F3_BYTE, 5'd6, 5'd1, 12'd6));
        prog.push_back(i_type(OP_LOAD, F3_BYTE, 5'd7, 5'd1, 12'd3));
        prog.push_back(i_type(OP_LOAD, F3_WORD, 5'd8, 5'd1, 12'd4));
        run_program("memory");

        prog = {};                                    // branches, each skips one filler
        prog.push_back(i_type(OP_IMM, 3'd0, 5'd1, 5'd0, 12'($urandom)));
        prog.push_back(i_type(OP_IMM, 3'd0, 5'd2, 5'd0, 12'($urandom)));
        prog.push_back(i_type(OP_IMM, 3'd0, 5'd3, 5'd1, 12'd0));
        prog.push_back(b_type(F3_BEQ, 5'd1, 5'd3, 13'd8));
        prog.push_back(i_type(OP_IMM, 3'd0, 5'd10, 5'd10, 12'd1));
        prog.push_back(b_type(F3_BEQ, 5'd1, 5'd2, 13'd8));
        prog.push_back(i_type(OP_IMM, 3'd0, 5'd10, 5'd10, 12'd1));
        prog.push_back(b_type(F3_BNE, 5'd1, 5'd2, 13'd8));
        prog.push_back(i_type(OP_IMM, 3'd0, 5'd10, 5'd10, 12'd1));
        prog.push_back(b_type(F3_BNE, 5'd1, 5'd3, 13'd8));
        prog.push_back(i_type(OP_IMM, 3'd0, 5'd10, 5'd10, 12'd1));
        prog.push_back(b_type(F3_BLT, 5'd1, 5'd2, 13'd8));
        prog.push_back(i_type(OP_IMM, 3'd0, 5'd10, 5'd10, 12'd1));
        prog.push_back(b_type(F3_BLT, 5'd2, 5'd1, 13'd8));
        prog.push_back(i_type(OP_IMM, 3'd0, 5'd10, 5'd10, 12'd1));
        run_program("branch");

        prog = {};                                    // jal and jalr
        prog.push_back(j_type(5'd5, 21'd8));                        // to 8
        prog.push_back(i_type(OP_IMM, 3'd0, 5'd10, 5'd10, 12'd1));
        prog.push_back(i_type(OP_IMM, 3'd0, 5'd6, 5'd0, 12'd17));
        prog.push_back(i_type(OP_JALR, 3'd0, 5'd7, 5'd6, 12'd4));   // 21, bit 0 cleared
        prog.push_back(i_type(OP_IMM, 3'd0, 5'd10, 5'd10, 12'd1));
        prog.push_back(j_type(5'd0, 21'd8));
        prog.push_back(i_type(OP_IMM, 3'd0, 5'd10, 5'd10, 12'd1));
        prog.push_back(i_type(OP_IMM, 3'd0, 5'd8, 5'd7, 12'd0));
        run_program("jump");

        prog = {};                                    // unsupported encodings
        prog.push_back({20'h12345, 5'd5, 7'b0110111});          // lui
        prog.push_back({20'h00abc, 5'd6, 7'b0010111});          // auipc
        prog.push_back(i_type(OP_LOAD, 3'b001, 5'd7, 5'd0, 12'd0));  // lh
        prog.push_back(s_type(3'b001, 5'd0, 5'd0, 12'd0));           // sh
        prog.push_back(b_type(3'b101, 5'd0, 5'd0, 13'd8));           // bge
        prog.push_back(i_type(OP_IMM, 3'd0, 5'd8, 5'd5, 12'd0));
        prog.push_back(i_type(OP_IMM, 3'd0, 5'd9, 5'd7, 12'd0));
        run_program("unsupported");

        $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
